/* buffer_pkg.sv */
`default_nettype none

package buffer_pkg;

    // cartridge-bus address, also the full memory address
    typedef logic [25:0] bus_addr_t;
    // address in the compact memory map
    typedef logic [18:0] compact_addr_t;
    typedef logic [2:0]  region_t;
    typedef logic [1:0]  feed_t;
    typedef logic [1:0]  occupier_t;
    typedef logic [1:0]  slot_t;
    typedef logic        source_t;

    localparam region_t REGION_CODE = 3'd0;
    localparam region_t REGION_FEED = 3'd1;
    localparam region_t REGION_KEY  = 3'd2;

    // also the row index into the feed tables below
    localparam feed_t FEED_VIDEO   = 2'd0;
    localparam feed_t FEED_SOUND_L = 2'd1;
    localparam feed_t FEED_SOUND_R = 2'd2;
    localparam feed_t FEED_NONE    = 2'd3;

    localparam occupier_t OCC_NONE = 2'd0;
    localparam occupier_t OCC_CART = 2'd1;
    localparam occupier_t OCC_USB  = 2'd2;

    localparam source_t SRC_CART = 1'b0;
    localparam source_t SRC_USB  = 1'b1;

    // full memory map
    localparam bus_addr_t CODE_BASE = 26'h0000000;
    localparam bus_addr_t CODE_MASK = 26'h0FFFFFF;
    localparam bus_addr_t KEY_BASE  = 26'h2000000;
    localparam bus_addr_t KEY_MASK  = 26'h000001F;

    // frame bases, indexed [feed][slot]
    localparam bus_addr_t FEED_BASE [3][3] = '{
        '{26'h1000000, 26'h1020000, 26'h1040000},
        '{26'h1E00000, 26'h1E00010, 26'h1E00020},
        '{26'h1F00000, 26'h1F00010, 26'h1F00020}
    };

    localparam bus_addr_t FEED_MASK [3] = '{
        26'h001FFFF,
        26'h000000F,
        26'h000000F
    };

    // compact memory map
    localparam compact_addr_t COMPACT_CODE_BASE = 19'h00000;
    localparam compact_addr_t COMPACT_CODE_MASK = 19'h01FFF;
    localparam compact_addr_t COMPACT_KEY_BASE  = 19'h22060;
    localparam compact_addr_t COMPACT_KEY_MASK  = 19'h0001F;

    // video slots all fold onto one compact frame
    localparam compact_addr_t COMPACT_FEED_BASE [3][3] = '{
        '{19'h02000, 19'h02000, 19'h02000},
        '{19'h22000, 19'h22010, 19'h22020},
        '{19'h22030, 19'h22040, 19'h22050}
    };

    localparam compact_addr_t COMPACT_FEED_MASK [3] = '{
        19'h1FFFF,
        19'h0000F,
        19'h0000F
    };

    // per-feed slot owners after reset
    localparam occupier_t OCC_RESET [3] = '{OCC_NONE, OCC_CART, OCC_USB};

endpackage

`default_nettype wire

/* feed_addr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module feed_addr_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  buffer_pkg::bus_addr_t     req_addr,
    input  buffer_pkg::source_t       req_source,
    input  logic                      ack,
    output logic                      dec_valid,
    output buffer_pkg::region_t       dec_region,
    output buffer_pkg::feed_t         dec_feed,
    output buffer_pkg::source_t       dec_source,
    output buffer_pkg::bus_addr_t     dec_offset,
    output buffer_pkg::compact_addr_t dec_compact_offset,
    output logic                      dec_frame_start
);
    import buffer_pkg::*;

    logic          busy;
    logic          accept;
    logic          frame_start;
    region_t       region;
    feed_t         feed;
    bus_addr_t     offset;
    compact_addr_t compact_offset;

    // one request in flight, held off until ack has been seen
    assign accept = req && !ack && !busy;

    always_comb begin
        region         = REGION_FEED;
        feed           = FEED_VIDEO;
        offset         = req_addr & FEED_MASK[FEED_VIDEO];
        compact_offset = req_addr[18:0] & COMPACT_FEED_MASK[FEED_VIDEO];
        if (req_addr[25]) begin
            region         = REGION_KEY;
            feed           = FEED_NONE;
            offset         = req_addr & KEY_MASK;
            compact_offset = req_addr[18:0] & COMPACT_KEY_MASK;
        end else if (!req_addr[24]) begin
            region         = REGION_CODE;
            feed           = FEED_NONE;
            offset         = req_addr & CODE_MASK;
            compact_offset = req_addr[18:0] & COMPACT_CODE_MASK;
        end else if (req_addr[24:20] == 5'b11110) begin
            feed           = FEED_SOUND_L;
            offset         = req_addr & FEED_MASK[FEED_SOUND_L];
            compact_offset = req_addr[18:0] & COMPACT_FEED_MASK[FEED_SOUND_L];
        end else if (req_addr[24:20] == 5'b11111) begin
            feed           = FEED_SOUND_R;
            offset         = req_addr & FEED_MASK[FEED_SOUND_R];
            compact_offset = req_addr[18:0] & COMPACT_FEED_MASK[FEED_SOUND_R];
        end
    end

    // first word of a frame
    assign frame_start = (region == REGION_FEED) && (offset == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            dec_valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_region         <= region;
            dec_feed           <= feed;
            dec_source         <= req_source;
            dec_offset         <= offset;
            dec_compact_offset <= compact_offset;
            dec_frame_start    <= frame_start;
        end
    end

endmodule

`default_nettype wire

/* frame_slot_allocator.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_slot_allocator (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dec_valid,
    input  buffer_pkg::region_t       dec_region,
    input  buffer_pkg::feed_t         dec_feed,
    input  buffer_pkg::source_t       dec_source,
    input  buffer_pkg::bus_addr_t     dec_offset,
    input  buffer_pkg::compact_addr_t dec_compact_offset,
    input  logic                      dec_frame_start,
    output logic                      alloc_valid,
    output buffer_pkg::bus_addr_t     alloc_base,
    output buffer_pkg::compact_addr_t alloc_compact_base,
    output buffer_pkg::bus_addr_t     alloc_offset,
    output buffer_pkg::compact_addr_t alloc_compact_offset
);
    import buffer_pkg::*;

    // slot owners, indexed [feed][slot]
    occupier_t     occ [3][3];

    feed_t         feed_sel;
    occupier_t     owner;
    slot_t         held_slot;
    slot_t         free_slot;
    bus_addr_t     base;
    compact_addr_t compact_base;

    // keep the table index in range for code and key requests
    assign feed_sel = (dec_feed == FEED_NONE) ? FEED_VIDEO : dec_feed;
    assign owner    = (dec_source == SRC_USB) ? OCC_USB : OCC_CART;

    // lowest matching slot wins
    always_comb begin
        held_slot = 2'd0;
        free_slot = 2'd0;
        for (int s = 2; s >= 0; s--) begin
            if (occ[feed_sel][s] == owner) begin
                held_slot = slot_t'(s);
            end
            if (occ[feed_sel][s] == OCC_NONE) begin
                free_slot = slot_t'(s);
            end
        end
    end

    always_comb begin
        case (dec_region)
            REGION_FEED: begin
                base         = FEED_BASE[feed_sel][held_slot];
                compact_base = COMPACT_FEED_BASE[feed_sel][held_slot];
            end
            REGION_KEY: begin
                base         = KEY_BASE;
                compact_base = COMPACT_KEY_BASE;
            end
            default: begin
                base         = CODE_BASE;
                compact_base = COMPACT_CODE_BASE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_valid <= 1'b0;
            for (int f = 0; f < 3; f++) begin
                for (int s = 0; s < 3; s++) begin
                    occ[f][s] <= OCC_RESET[s];
                end
            end
        end else begin
            alloc_valid <= dec_valid;
            // swap lands next cycle, so this request still uses the old slot
            if (dec_valid && dec_frame_start) begin
                occ[feed_sel][free_slot] <= owner;
                occ[feed_sel][held_slot] <= OCC_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            alloc_base           <= base;
            alloc_compact_base   <= compact_base;
            alloc_offset         <= dec_offset;
            alloc_compact_offset <= dec_compact_offset;
        end
    end

endmodule

`default_nettype wire

/* buffer_addr_composer.sv */
`timescale 1ns/10ps
`default_nettype none

module buffer_addr_composer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  logic                      alloc_valid,
    input  buffer_pkg::bus_addr_t     alloc_base,
    input  buffer_pkg::compact_addr_t alloc_compact_base,
    input  buffer_pkg::bus_addr_t     alloc_offset,
    input  buffer_pkg::compact_addr_t alloc_compact_offset,
    output logic                      ack,
    output buffer_pkg::bus_addr_t     mem_addr,
    output buffer_pkg::compact_addr_t compact_addr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ack          <= 1'b0;
            mem_addr     <= '0;
            compact_addr <= '0;
        end else if (alloc_valid) begin
            ack          <= 1'b1;
            mem_addr     <= alloc_base + alloc_offset;
            compact_addr <= alloc_compact_base + alloc_compact_offset;
        end else if (!req) begin
            // addresses stay put, only the handshake closes
            ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* cart_buffer_mapper.sv */
`timescale 1ns/10ps
`default_nettype none

module cart_buffer_mapper (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  buffer_pkg::bus_addr_t     req_addr,
    input  buffer_pkg::source_t       req_source,
    output logic                      ack,
    output buffer_pkg::bus_addr_t     mem_addr,
    output buffer_pkg::compact_addr_t compact_addr
);
    import buffer_pkg::*;

    logic          dec_valid;
    region_t       dec_region;
    feed_t         dec_feed;
    source_t       dec_source;
    bus_addr_t     dec_offset;
    compact_addr_t dec_compact_offset;
    logic          dec_frame_start;

    logic          alloc_valid;
    bus_addr_t     alloc_base;
    compact_addr_t alloc_compact_base;
    bus_addr_t     alloc_offset;
    compact_addr_t alloc_compact_offset;

    // stage 1, ack fed back to hold off the next accept
    feed_addr_decoder feed_addr_decoder_inst (
        .clk                (clk),
        .rst                (rst),
        .req                (req),
        .req_addr           (req_addr),
        .req_source         (req_source),
        .ack                (ack),
        .dec_valid          (dec_valid),
        .dec_region         (dec_region),
        .dec_feed           (dec_feed),
        .dec_source         (dec_source),
        .dec_offset         (dec_offset),
        .dec_compact_offset (dec_compact_offset),
        .dec_frame_start    (dec_frame_start)
    );

    // stage 2
    frame_slot_allocator frame_slot_allocator_inst (
        .clk                  (clk),
        .rst                  (rst),
        .dec_valid            (dec_valid),
        .dec_region           (dec_region),
        .dec_feed             (dec_feed),
        .dec_source           (dec_source),
        .dec_offset           (dec_offset),
        .dec_compact_offset   (dec_compact_offset),
        .dec_frame_start      (dec_frame_start),
        .alloc_valid          (alloc_valid),
        .alloc_base           (alloc_base),
        .alloc_compact_base   (alloc_compact_base),
        .alloc_offset         (alloc_offset),
        .alloc_compact_offset (alloc_compact_offset)
    );

    // stage 3
    buffer_addr_composer buffer_addr_composer_inst (
        .clk                  (clk),
        .rst                  (rst),
        .req                  (req),
        .alloc_valid          (alloc_valid),
        .alloc_base           (alloc_base),
        .alloc_compact_base   (alloc_compact_base),
        .alloc_offset         (alloc_offset),
        .alloc_compact_offset (alloc_compact_offset),
        .ack                  (ack),
        .mem_addr             (mem_addr),
        .compact_addr         (compact_addr)
    );

endmodule

`default_nettype wire

/* cart_buffer_mapper_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module cart_buffer_mapper_chk (
    input logic                      clk,
    input logic                      rst,
    input logic                      req,
    input logic                      ack,
    input buffer_pkg::bus_addr_t     mem_addr,
    input buffer_pkg::compact_addr_t compact_addr
);

    int fail_count = 0;

    // ack is only set while a request is up
    ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else begin
            $error("ack rose without req");
            fail_count++;
        end

    ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell while req was still high");
            fail_count++;
        end

    // outputs held for the whole ack phase
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> ($stable(mem_addr) && $stable(compact_addr)))
        else begin
            $error("mapped address changed while ack was high");
            fail_count++;
        end

endmodule

bind cart_buffer_mapper cart_buffer_mapper_chk cart_buffer_mapper_chk_inst (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .ack          (ack),
    .mem_addr     (mem_addr),
    .compact_addr (compact_addr)
);

`default_nettype wire

/* cart_buffer_mapper_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cart_buffer_mapper_tb;

    localparam int CYCLE_LIMIT = 4000;
    localparam int RANDOM_TXNS = 200;
    // edges from the accepting edge up to the one that sets ack
    localparam int ACK_EDGES = 3;

    logic        clk;
    logic        rst;
    logic        req;
    logic [25:0] req_addr;
    logic        req_source;
    logic        ack;
    logic [25:0] mem_addr;
    logic [18:0] compact_addr;

    // reference occupancy, indexed [feed][slot]; 0 free, 1 cart, 2 usb
    logic [1:0]  ref_occ [3][3];
    logic [31:0] lfsr_state = 32'hccad;
    logic [25:0] cur_addr = '0;
    logic        cur_source = 1'b0;
    logic [25:0] got_mem;
    logic [18:0] got_compact;
    logic        ack_seen = 1'b0;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          latency_errors = 0;

    cart_buffer_mapper cart_buffer_mapper_inst (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_addr     (req_addr),
        .req_source   (req_source),
        .ack          (ack),
        .mem_addr     (mem_addr),
        .compact_addr (compact_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // mostly feeds, and one in four with a zero frame offset
    function automatic logic [25:0] random_addr();
        logic [31:0] kind;
        logic [31:0] r;
        logic [25:0] addr;
        kind = take_bits(3);
        r = take_bits(25);
        case (kind[2:0])
            3'd0: addr = {2'b00, r[23:0]};
            3'd1: addr = {1'b1, r[24:0]};
            3'd2, 3'd3: addr = {3'b010, r[22:0]};
            3'd4, 3'd5: addr = {6'b011110, r[19:0]};
            default: addr = {6'b011111, r[19:0]};
        endcase
        if (take_bits(2) == 0) begin
            addr[16:0] = '0;
        end
        return addr;
    endfunction

    function automatic logic [25:0] full_frame_base(input logic [1:0] feed, input logic [1:0] slot);
        logic [25:0] s;
        s = {24'd0, slot};
        case (feed)
            2'd1: return 26'h1E00000 + (s << 4);
            2'd2: return 26'h1F00000 + (s << 4);
            default: return 26'h1000000 + (s << 17);
        endcase
    endfunction

    // video slots share one compact frame
    function automatic logic [18:0] compact_frame_base(input logic [1:0] feed, input logic [1:0] slot);
        logic [18:0] s;
        s = {17'd0, slot};
        case (feed)
            2'd1: return 19'h22000 + (s << 4);
            2'd2: return 19'h22030 + (s << 4);
            default: return 19'h02000;
        endcase
    endfunction

    // expected addresses from the pre-swap slot, then the frame swap
    function automatic void ref_map(input logic [25:0] addr, input logic src,
                                    output logic [25:0] full, output logic [18:0] compact);
        logic [1:0]  feed;
        logic [1:0]  who;
        logic [1:0]  held;
        logic [1:0]  free_slot;
        logic [25:0] off;
        who = src ? 2'd2 : 2'd1;
        if (addr[25]) begin
            full = 26'h2000000 + (addr & 26'h1F);
            compact = 19'h22060 + (addr[18:0] & 19'h1F);
        end else if (!addr[24]) begin
            full = addr & 26'hFFFFFF;
            compact = addr[18:0] & 19'h1FFF;
        end else begin
            if (addr[24:20] == 5'b11110) begin
                feed = 2'd1;
            end else if (addr[24:20] == 5'b11111) begin
                feed = 2'd2;
            end else begin
                feed = 2'd0;
            end
            off = addr & ((feed == 2'd0) ? 26'h1FFFF : 26'hF);
            held = 2'd3;
            free_slot = 2'd3;
            for (int s = 0; s < 3; s++) begin
                if (held == 2'd3 && ref_occ[feed][s] == who) begin
                    held = 2'(s);
                end
                if (free_slot == 2'd3 && ref_occ[feed][s] == 2'd0) begin
                    free_slot = 2'(s);
                end
            end
            full = full_frame_base(feed, held) + off;
            compact = compact_frame_base(feed, held) + off[18:0];
            if (off == 0) begin
                ref_occ[feed][free_slot] = who;
                ref_occ[feed][held] = 2'd0;
            end
        end
    endfunction

    // compares each new ack against the reference model
    always @(negedge clk) begin
        logic [25:0] exp_mem;
        logic [18:0] exp_compact;
        if (rst || !ack) begin
            ack_seen = 1'b0;
        end else if (!ack_seen) begin
            ack_seen = 1'b1;
            ref_map(cur_addr, cur_source, exp_mem, exp_compact);
            check_count += 2;
            if (mem_addr !== exp_mem) begin
                $display("FAIL mem_addr for %h: expected %h, got %h", cur_addr, exp_mem, mem_addr);
                error_count++;
            end
            if (compact_addr !== exp_compact) begin
                $display("FAIL compact_addr for %h: expected %h, got %h",
                         cur_addr, exp_compact, compact_addr);
                error_count++;
            end
        end
    end

    // one four-phase transaction, entered and left 5 ns after an edge
    task automatic run_txn(input logic [25:0] addr, input logic src);
        int edges;
        edges = 0;
        cur_addr = addr;
        cur_source = src;
        req_addr = addr;
        req_source = src;
        req = 1'b1;
        do begin
            @(posedge clk);
            #5;
            edges++;
        end while (!ack);
        got_mem = mem_addr;
        got_compact = compact_addr;
        if (edges != ACK_EDGES) begin
            $display("FAIL ack latency: expected %h, got %h", ACK_EDGES, edges);
            latency_errors++;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #5;
        end while (ack);
    endtask

    task automatic check_addr(input logic [25:0] exp_mem, input logic [18:0] exp_compact);
        check_count += 2;
        if (got_mem !== exp_mem) begin
            $display("FAIL mem_addr: expected %h, got %h", exp_mem, got_mem);
            error_count++;
        end
        if (got_compact !== exp_compact) begin
            $display("FAIL compact_addr: expected %h, got %h", exp_compact, got_compact);
            error_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, error_count - errors_before);
        end
    endtask

    initial begin
        int start;
        int total;
        logic [31:0] bits;
        rst = 1'b1;
        req = 1'b0;
        req_addr = '0;
        req_source = 1'b0;
        for (int f = 0; f < 3; f++) begin
            ref_occ[f][0] = 2'd0;
            ref_occ[f][1] = 2'd1;
            ref_occ[f][2] = 2'd2;
        end
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b0;

        start = error_count;
        check_count += 3;
        if (ack !== 1'b0) begin
            $display("FAIL ack: expected %h, got %h", 1'b0, ack);
            error_count++;
        end
        if (mem_addr !== '0) begin
            $display("FAIL mem_addr: expected %h, got %h", 26'h0, mem_addr);
            error_count++;
        end
        if (compact_addr !== '0) begin
            $display("FAIL compact_addr: expected %h, got %h", 19'h0, compact_addr);
            error_count++;
        end
        report_test(1, "reset state", start);

        start = error_count;
        run_txn(26'h0123456, 1'b0);
        check_addr(26'h0123456, 19'h01456);
        run_txn(26'h2000013, 1'b1);
        check_addr(26'h2000013, 19'h22073);
        report_test(2, "code and key", start);

        // cart sits in slot 1 and usb in slot 2 after reset
        start = error_count;
        run_txn(26'h1000123, 1'b0);
        check_addr(26'h1020123, 19'h02123);
        run_txn(26'h1000040, 1'b1);
        check_addr(26'h1040040, 19'h02040);
        run_txn(26'h1F00007, 1'b0);
        check_addr(26'h1F00017, 19'h22047);
        run_txn(26'h1F00002, 1'b1);
        check_addr(26'h1F00022, 19'h22052);
        report_test(3, "reset slots", start);

        start = error_count;
        run_txn(26'h1E00000, 1'b0);
        check_addr(26'h1E00010, 19'h22010);
        run_txn(26'h1E00005, 1'b0);
        check_addr(26'h1E00005, 19'h22005);
        run_txn(26'h1E00000, 1'b1);
        check_addr(26'h1E00020, 19'h22020);
        run_txn(26'h1E00003, 1'b1);
        check_addr(26'h1E00013, 19'h22013);
        report_test(4, "frame swap", start);

        start = error_count;
        for (int i = 0; i < RANDOM_TXNS; i++) begin
            bits = take_bits(1);
            run_txn(random_addr(), bits[0]);
        end
        report_test(5, "random traffic", start);

        if (latency_errors == 0) begin
            $display("test 6 ack latency: ok");
        end else begin
            $display("test 6 ack latency: %0d errors", latency_errors);
        end

        total = error_count + latency_errors +
                cart_buffer_mapper_inst.cart_buffer_mapper_chk_inst.fail_count;
        $display("summary: %0d checks, %0d value errors, %0d latency errors, %0d assertion errors",
                 check_count, error_count, latency_errors,
                 cart_buffer_mapper_inst.cart_buffer_mapper_chk_inst.fail_count);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cart_buffer_mapper.f */
buffer_pkg.sv
feed_addr_decoder.sv
frame_slot_allocator.sv
buffer_addr_composer.sv
cart_buffer_mapper.sv
cart_buffer_mapper_chk.sv
cart_buffer_mapper_tb.sv
